//--- verilog/window_config.svh
`ifndef WINDOW_CONFIG_SVH
`define WINDOW_CONFIG_SVH

// Samples per analysis frame
`define FRAME_LEN   306

`define SAMPLE_W    16
`define COEF_W      16

// Coefficients are Q1.15, so the product is scaled back by 15 bits
`define COEF_SHIFT  15

// Sink buffer depth seen from the window unit
`define OUT_CREDITS 4

// Wide enough to index FRAME_LEN entries
`define PTR_W       9

`endif

//--- verilog/window_pkg.sv
`include "window_config.svh"

package window_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    typedef logic signed [`COEF_W-1:0] coef_t;

    // Position of a sample inside one frame
    typedef logic [`PTR_W-1:0] frame_ptr_t;

    // Window unit sequencer
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DRAIN,
        FINISH
    } win_state_t;

endpackage

//--- verilog/window_coeff_rom.sv
`timescale 1ns/1ns
`include "window_config.svh"

module window_coeff_rom
    import window_pkg::*;
(
    input  logic       clk,
    input  frame_ptr_t addr_i,
    output coef_t      coef_o
);
    localparam real PI = 3.14159265358979323846;

    coef_t rom [0:`FRAME_LEN-1];

    // Hamming weight in Q1.15, rounded to the nearest integer
    function automatic coef_t hamming_coef(input int n);
        real w;
        w = 0.54 - 0.46 * $cos(2.0 * PI * n / (`FRAME_LEN - 1));
        return coef_t'($rtoi(32767.0 * w + 0.5));
    endfunction

    initial begin
        for (int n = 0; n < `FRAME_LEN; n++) begin
            rom[n] = hamming_coef(n);
        end
    end

    always_ff @(posedge clk) begin
        coef_o <= rom[addr_i]; // Lines up with the frame buffer read data
    end

endmodule

//--- verilog/frame_buffer.sv
`timescale 1ns/1ns
`include "window_config.svh"

module frame_buffer
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_valid_i,
    input  sample_t    sample_i,
    input  logic       rd_en_i,
    input  frame_ptr_t rd_ptr_i,
    input  logic       frame_release_i,
    output logic       frame_avail_o,
    output sample_t    rd_sample_o,
    output logic       overflow_o
);
    localparam frame_ptr_t LAST_PTR = frame_ptr_t'(`FRAME_LEN - 1);

    sample_t    mem [0:1][0:`FRAME_LEN-1];
    frame_ptr_t wr_ptr;
    logic       wr_bank;
    logic       rd_bank;
    logic [1:0] bank_full;
    logic       wr_ok;
    logic       wr_wrap;
    logic       drop;

    // The write bank only switches after a fill, so a full write bank
    // means the other bank is still waiting to be read as well
    assign drop    = sample_valid_i && bank_full[wr_bank];
    assign wr_ok   = sample_valid_i && !bank_full[wr_bank];
    assign wr_wrap = wr_ok && (wr_ptr == LAST_PTR);

    assign frame_avail_o = bank_full[rd_bank];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_bank][wr_ptr] <= sample_i;
        end
        if (rd_en_i) begin
            rd_sample_o <= mem[rd_bank][rd_ptr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            wr_bank    <= 1'b0;
            rd_bank    <= 1'b0;
            bank_full  <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_wrap ? '0 : wr_ptr + 1'b1;
            end

            if (wr_wrap) begin
                bank_full[wr_bank] <= 1'b1;
                wr_bank            <= ~wr_bank;
            end

            // A released bank is never the one being filled, so this cannot clear the bit set above
            if (frame_release_i) begin
                bank_full[rd_bank] <= 1'b0;
                rd_bank            <= ~rd_bank;
            end

            if (drop) begin
                overflow_o <= 1'b1; // Sticky until reset
            end
        end
    end

    // The window unit may only read and release a bank that holds a frame
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_release_i |-> bank_full[rd_bank])
    else $error("frame_buffer: release of an empty read bank");

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_en_i |-> frame_avail_o)
    else $error("frame_buffer: read issued with no frame available");

endmodule

//--- verilog/hamming_window.sv
`timescale 1ns/1ns
`include "window_config.svh"

module hamming_window
    import window_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_avail_i,
    input  sample_t    rd_sample_i,
    input  coef_t      coef_i,
    input  logic       credit_return_i,
    output logic       rd_en_o,
    output frame_ptr_t rd_ptr_o,
    output logic       frame_release_o,
    output logic       out_valid_o,
    output sample_t    win_sample_o,
    output logic       frame_last_o,
    output logic       done_o
);
    localparam int         CRED_W   = $clog2(`OUT_CREDITS + 1);
    localparam frame_ptr_t LAST_PTR = frame_ptr_t'(`FRAME_LEN - 1);

    win_state_t        state;
    frame_ptr_t        rd_ptr;
    logic [CRED_W-1:0] credits;
    logic              issue;
    logic              last_rd;
    logic              s1_valid;
    logic              s1_last;

    logic signed [`SAMPLE_W+`COEF_W-1:0] product;
    logic signed [`SAMPLE_W+`COEF_W-1:0] shifted;

    // One read per cycle, each one holding a slot in the sink
    assign issue   = (state == CALC) && (credits != '0);
    assign last_rd = issue && (rd_ptr == LAST_PTR);

    assign rd_en_o         = issue;
    assign rd_ptr_o        = rd_ptr;
    assign frame_release_o = last_rd; // Bank is handed back with its last read
    assign done_o          = (state == FINISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            rd_ptr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_avail_i) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    if (last_rd) begin
                        rd_ptr <= '0;
                        state  <= DRAIN;
                    end else if (issue) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                DRAIN: begin
                    // Last windowed sample is on the output this cycle
                    if (frame_last_o) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(`OUT_CREDITS);
        end else begin
            credits <= credits - CRED_W'(issue) + CRED_W'(credit_return_i);
        end
    end

    // Stage one is the memory and ROM read, stage two the product register
    assign product = rd_sample_i * coef_i;
    assign shifted = product >>> `COEF_SHIFT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s1_last      <= 1'b0;
            out_valid_o  <= 1'b0;
            frame_last_o <= 1'b0;
        end else begin
            s1_valid     <= issue;
            s1_last      <= last_rd;
            out_valid_o  <= s1_valid;
            frame_last_o <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            win_sample_o <= shifted[`SAMPLE_W-1:0]; // Truncate back to sample width
        end
    end

    // A sink that returns more credits than it was given breaks the count
    assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(`OUT_CREDITS))
    else $error("hamming_window: credit count above %0d", `OUT_CREDITS);

    // An output still holds the credit reserved for it, so the count cannot be full
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> (credits < CRED_W'(`OUT_CREDITS)))
    else $error("hamming_window: output without a reserved credit");

endmodule

//--- verilog/speech_window_top.sv
`timescale 1ns/1ns
`include "window_config.svh"

module speech_window_top
    import window_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sample_valid_i,
    input  sample_t sample_i,
    input  logic    credit_return_i,
    output logic    out_valid_o,
    output sample_t win_sample_o,
    output logic    frame_last_o,
    output logic    done_o,
    output logic    overflow_o
);
    logic       frame_avail;
    logic       rd_en;
    frame_ptr_t rd_ptr;
    logic       frame_release;
    sample_t    rd_sample;
    coef_t      coef;

    frame_buffer i_frame_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .sample_valid_i  (sample_valid_i),
        .sample_i        (sample_i),
        .rd_en_i         (rd_en),
        .rd_ptr_i        (rd_ptr),
        .frame_release_i (frame_release),
        .frame_avail_o   (frame_avail),
        .rd_sample_o     (rd_sample),
        .overflow_o      (overflow_o)
    );

    // Coefficient address follows the sample pointer
    window_coeff_rom i_coeff_rom (
        .clk    (clk),
        .addr_i (rd_ptr),
        .coef_o (coef)
    );

    hamming_window i_hamming_window (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_avail_i   (frame_avail),
        .rd_sample_i     (rd_sample),
        .coef_i          (coef),
        .credit_return_i (credit_return_i),
        .rd_en_o         (rd_en),
        .rd_ptr_o        (rd_ptr),
        .frame_release_o (frame_release),
        .out_valid_o     (out_valid_o),
        .win_sample_o    (win_sample_o),
        .frame_last_o    (frame_last_o),
        .done_o          (done_o)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- verification/tb_speech_window.sv
`timescale 1ns/1ns
`include "window_config.svh"

module tb_speech_window
    import window_pkg::*;
();
    localparam int  SEED           = 95929;
    localparam int  NUM_FRAMES     = 11; // Frames sent over all five tests
    localparam int  TIMEOUT_CYCLES = 4 * (NUM_FRAMES * `FRAME_LEN * 7);
    localparam real PI             = 3.14159265358979323846;

    // Sink behaviour
    localparam int SINK_NOW      = 0;
    localparam int SINK_RANDOM   = 1;
    localparam int SINK_WITHHOLD = 2;

    logic    clk;
    logic    rst_n;
    logic    sample_valid  = 1'b0;
    sample_t sample        = '0;
    logic    credit_return = 1'b0;
    logic    out_valid;
    sample_t win_sample;
    logic    frame_last;
    logic    done;
    logic    overflow;

    int      seed         = SEED;
    int      credit_seed  = SEED;
    int      cycle        = 0;
    int      error_count  = 0;
    int      tests_ok     = 0;
    int      tests_bad    = 0;
    int      sink_mode    = SINK_NOW;
    int      sent_count   = 0;
    int      out_count    = 0;
    int      last_count   = 0;
    int      done_count   = 0;
    int      received     = 0;
    int      returned     = 0;
    logic    last_seen    = 1'b0;
    sample_t first_value  = '0;
    sample_t last_value   = '0;

    sample_t exp_sample_q [$];
    int      exp_index_q  [$];
    int      due_q        [$]; // Cycle at which each credit goes back

    tb_clock_gen #(
        .PERIOD       (4),
        .RESET_CYCLES (2)
    ) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    speech_window_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .sample_valid_i  (sample_valid),
        .sample_i        (sample),
        .credit_return_i (credit_return),
        .out_valid_o     (out_valid),
        .win_sample_o    (win_sample),
        .frame_last_o    (frame_last),
        .done_o          (done),
        .overflow_o      (overflow)
    );

    // Expected windowed sample straight from the Hamming formula
    function automatic sample_t ref_window(input sample_t s, input int n);
        real    w;
        int     coef;
        longint prod;
        w    = 0.54 - 0.46 * $cos(2.0 * PI * n / (`FRAME_LEN - 1));
        coef = $rtoi(32767.0 * w + 0.5);
        prod = longint'(s) * longint'(coef);
        return sample_t'(prod >>> `COEF_SHIFT);
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the outputs never completed", cycle);
            $display("TESTS FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin : compare_outputs
        sample_t s;
        sample_t expected;
        int      n;
        if (rst_n && out_valid) begin
            assert (exp_sample_q.size() > 0)
            else begin
                $display("Error at %0t: an output came with no sample waiting for it", $time);
                error_count++;
            end
            if (exp_sample_q.size() > 0) begin
                s        = exp_sample_q.pop_front();
                n        = exp_index_q.pop_front();
                expected = ref_window(s, n);
                assert (win_sample === expected)
                else begin
                    $display("MISMATCH at %0t: win_sample_o expected %0d actual %0d",
                             $time, expected, win_sample);
                    error_count++;
                end
                assert (frame_last === (n == `FRAME_LEN - 1))
                else begin
                    $display("MISMATCH at %0t: frame_last_o expected %0b actual %0b",
                             $time, (n == `FRAME_LEN - 1), frame_last);
                    error_count++;
                end
                if (n == 0) begin
                    first_value = win_sample;
                end
                if (n == `FRAME_LEN - 1) begin
                    last_value = win_sample;
                end
            end
            out_count++;
            if (frame_last) begin
                last_count++;
            end
        end
    end

    // done must follow the last sample of a frame by exactly one cycle
    always @(posedge clk) begin : check_done
        if (rst_n) begin
            assert (done === last_seen)
            else begin
                if (done) begin
                    $display("Error at %0t: done_o pulsed without a last sample before it",
                             $time);
                end else begin
                    $display("Error at %0t: done_o missing after the last sample", $time);
                end
                error_count++;
            end
            if (done) begin
                done_count++;
            end
            last_seen = out_valid && frame_last;
        end
    end

    always @(posedge clk) begin : sink_model
        int delay;
        credit_return <= 1'b0;
        if (rst_n) begin
            if (out_valid) begin
                delay = (sink_mode == SINK_RANDOM) ? ($unsigned($random(credit_seed)) % 6) : 0;
                due_q.push_back(cycle + delay);
                received++;
            end
            if (sink_mode != SINK_WITHHOLD && due_q.size() > 0 && due_q[0] <= cycle) begin
                credit_return <= 1'b1; // One credit per cycle at most
                void'(due_q.pop_front());
                returned++;
            end
            assert (received - returned <= `OUT_CREDITS)
            else begin
                $display("Error at %0t: %0d outputs unreturned, the sink holds only %0d",
                         $time, received - returned, `OUT_CREDITS);
                error_count++;
            end
        end
    end

    task automatic send_frames(input int frames, input int gap, input bit random_data);
        sample_t s;
        for (int i = 0; i < frames * `FRAME_LEN; i++) begin
            s = random_data ? sample_t'($random(seed)) : sample_t'(16'sd32767);
            @(posedge clk);
            sample_valid <= 1'b1;
            sample       <= s;
            exp_sample_q.push_back(s);
            exp_index_q.push_back(sent_count % `FRAME_LEN);
            sent_count++;
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                sample_valid <= 1'b0;
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // Waits for the frames to finish and for every credit to go back
    task automatic wait_frames(input int target);
        while (done_count < target) @(posedge clk);
        while (due_q.size() > 0) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic check_drained();
        assert (exp_sample_q.size() == 0)
        else begin
            $display("Error at %0t: %0d samples never came out", $time, exp_sample_q.size());
            error_count++;
        end
    endtask

    task automatic check_no_overflow();
        assert (overflow === 1'b0)
        else begin
            $display("Error at %0t: overflow_o rose while the input rate was sustainable",
                     $time);
            error_count++;
        end
    endtask

    task automatic end_test(input int num, input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: failing with %0d errors", num, name,
                     error_count - errors_before);
        end
    endtask

    initial begin : main
        int errors_before;
        int done_before;
        int out_before;
        int last_before;
        wait (rst_n === 1'b1);
        @(posedge clk);

        errors_before = error_count;
        done_before   = done_count;
        sink_mode     = SINK_NOW;
        send_frames(1, 1, 1'b0);
        wait_frames(done_before + 1);
        check_drained();
        assert (first_value === 16'sd2620)
        else begin
            $display("MISMATCH at %0t: win_sample_o first expected 2620 actual %0d",
                     $time, first_value);
            error_count++;
        end
        assert (last_value === 16'sd2620)
        else begin
            $display("MISMATCH at %0t: win_sample_o last expected 2620 actual %0d",
                     $time, last_value);
            error_count++;
        end
        check_no_overflow();
        end_test(1, "full-scale frame", errors_before);

        errors_before = error_count;
        done_before   = done_count;
        out_before    = out_count;
        last_before   = last_count;
        send_frames(3, 1, 1'b1);
        wait_frames(done_before + 3);
        check_drained();
        assert (last_count - last_before == 3 && out_count - out_before == 3 * `FRAME_LEN)
        else begin
            $display("Error at %0t: %0d last flags over %0d outputs, expected 3 over %0d",
                     $time, last_count - last_before, out_count - out_before,
                     3 * `FRAME_LEN);
            error_count++;
        end
        check_no_overflow();
        end_test(2, "random frames back to back", errors_before);

        errors_before = error_count;
        done_before   = done_count;
        sink_mode     = SINK_RANDOM;
        send_frames(2, 3, 1'b1);
        wait_frames(done_before + 2);
        check_drained();
        check_no_overflow();
        end_test(3, "random credit delays", errors_before);

        errors_before = error_count;
        done_before   = done_count;
        last_before   = last_count;
        sink_mode     = SINK_NOW;
        send_frames(2, 1, 1'b1);
        wait_frames(done_before + 2);
        check_drained();
        assert (done_count - done_before == 2 && last_count - last_before == 2)
        else begin
            $display("Error at %0t: %0d done pulses for %0d frames, expected 2 for 2",
                     $time, done_count - done_before, last_count - last_before);
            error_count++;
        end
        check_no_overflow();
        end_test(4, "done per frame", errors_before);

        // Nothing goes back to the DUT, so only the reserved credits drain
        errors_before = error_count;
        out_before    = out_count;
        sink_mode     = SINK_WITHHOLD;
        send_frames(3, 0, 1'b1);
        repeat (8) @(posedge clk);
        assert (overflow === 1'b1)
        else begin
            $display("Error at %0t: overflow_o stayed low with both banks full", $time);
            error_count++;
        end
        assert (out_count - out_before == `OUT_CREDITS)
        else begin
            $display("Error at %0t: %0d outputs with no credits returned, expected %0d",
                     $time, out_count - out_before, `OUT_CREDITS);
            error_count++;
        end
        end_test(5, "overflow under back-pressure", errors_before);

        $display("Summary: %0d tests ok, %0d failing, %0d check errors",
                 tests_ok, tests_bad, error_count);
        if (tests_bad == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/window_pkg.sv
verilog/window_coeff_rom.sv
verilog/frame_buffer.sv
verilog/hamming_window.sv
verilog/speech_window_top.sv
verification/tb_clock_gen.sv
verification/tb_speech_window.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_speech_window -f src.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
exit 0
